/* Makefile */
TOP = st_glue_tb
LOG = sim.log

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(shell cat sources.f)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all compile run clean

/* bench/clock_gen.sv */
// testbench clock and power-on reset, 40 ns clk_8 with pll_locked low for the first cycles
`timescale 1ns/1ns

module clock_gen #(
	parameter int period_ns    = 40,
	parameter int reset_cycles = 3
) (
	output logic clk_8,
	output logic pll_locked
);
	initial begin
		clk_8 = 1'b0;
		forever #(period_ns / 2) clk_8 = ~clk_8;
	end

	initial begin
		pll_locked = 1'b0;  // pll not locked yet
		repeat (reset_cycles) @(posedge clk_8);
		#5 pll_locked = 1'b1;  // release just after an edge
	end
endmodule

/* bench/st_glue_sva.sv */
// st glue bus protocol checks, bound into the top level
`timescale 1ns/1ns

module st_glue_sva (
	input logic                  clk_8,
	input logic                  pll_locked,
	input logic                  br,
	input logic                  dtack_n,
	input logic                  berr,
	input st_glue_pkg::ram_req_t ram
);
	int fail_count = 0;  // failed checks so far, polled by the testbench

	// a cpu cycle ends one way only
	dtack_berr_excl: assert property (@(posedge clk_8) disable iff (!pll_locked)
		!(!dtack_n && berr)) else begin
		$error("dtack and bus error active in the same cycle");
		fail_count = fail_count + 1;
	end

	br_holds_dtack: assert property (@(posedge clk_8) disable iff (!pll_locked)
		br |-> dtack_n) else begin  // bus request stalls the cpu
		$error("dtack given while bus request is high");
		fail_count = fail_count + 1;
	end

	ram_we_oe_excl: assert property (@(posedge clk_8) disable iff (!pll_locked)
		!(ram.we && ram.oe)) else begin
		$error("ram read and write enabled together");
		fail_count = fail_count + 1;
	end
endmodule

bind st_glue st_glue_sva i_st_glue_sva (
	.clk_8(clk_8), .pll_locked(pll_locked), .br(br),
	.dtack_n(dtack_n), .berr(berr), .ram(ram)
);

/* bench/st_glue_tb.sv */
// st glue testbench: directed ram, memory map, rom, io and interrupt tests
`timescale 1ns/1ns

module st_glue_tb;
	import st_glue_pkg::*;

	localparam int cycle_wait     = 48;   // dtack or berr must come within this
	localparam int bus_cycles     = 60;   // upper bound on cpu cycles over all tests
	localparam int timeout_cycles = bus_cycles * cycle_wait + 120;  // 3000 clocks

	logic        clk_8;
	logic        pll_locked;
	cpu_bus_t    cpu;
	logic        br, clr_berr, dtack_n, berr;
	logic [2:0]  ipl_n;
	logic [15:0] rdata, ram_rdata;
	ram_req_t    ram;
	logic [22:0] video_addr;
	logic        video_read, vsync, hsync, mfp_irq, mfp_iack;
	io_sel_t     io_sel;
	io_rdata_t   io_rdata;
	mem_size_e   mem_size;

	// what the last cpu cycle saw in its final cycle
	logic        ended_dtack, ended_berr, seen_mfp_iack, seen_ram_write;
	logic [15:0] seen_rdata;
	io_sel_t     seen_sel;
	string       test_name;
	logic [15:0] lfsr = 16'd3584;
	int          cycle_count = 0;

	clock_gen i_clock_gen (.clk_8, .pll_locked);

	st_glue #(.WATCHDOG_LIMIT(7)) i_st_glue (
		.clk_8, .pll_locked, .cpu, .br, .clr_berr, .dtack_n, .berr, .ipl_n, .rdata,
		.ram, .ram_rdata, .video_addr, .video_read, .vsync, .hsync,
		.io_sel, .io_rdata, .mfp_irq, .mfp_iack, .mem_size
	);

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
		assert (actual === expected) else stop_with_failure($sformatf(
			"FAIL %s %s: expected 0x%0h, actual 0x%0h", test_name, what, expected, actual));
	endtask

	task automatic check_true(input logic cond, input string msg);
		assert (cond) else stop_with_failure($sformatf("%s: %s", test_name, msg));
	endtask

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};  // one step per bit
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	function automatic logic [22:0] word_of(input logic [23:0] byte_addr);
		return byte_addr[23:1];
	endfunction

	task automatic next_edge();
		@(posedge clk_8);
		#5;  // drive point
	endtask

	// one cpu bus cycle, holds as_n low until dtack or berr
	task automatic cpu_cycle(input logic [22:0] addr, input logic rw, input logic [15:0] wdata);
		int waited;
		waited = 0;
		ended_dtack = 1'b0;
		ended_berr = 1'b0;
		seen_ram_write = 1'b0;
		cpu.addr = addr;
		cpu.rw = rw;
		cpu.wdata = wdata;
		cpu.uds_n = 1'b0;
		cpu.lds_n = 1'b0;
		cpu.as_n = 1'b0;
		while (!ended_dtack && !ended_berr) begin
			@(negedge clk_8);  // outputs settled here
			if (ram.we && ram.addr == addr && ram.wdata == wdata)
				seen_ram_write = 1'b1;
			ended_dtack = !dtack_n;
			ended_berr = berr;
			seen_rdata = rdata;
			seen_sel = io_sel;
			seen_mfp_iack = mfp_iack;
			waited++;
			if (waited >= cycle_wait && !ended_dtack && !ended_berr)
				stop_with_failure($sformatf("%s: no DTACK and no bus error for 0x%h within %0d cycles",
					test_name, addr, cycle_wait));
		end
		next_edge();
		cpu.as_n = 1'b1;
		cpu.uds_n = 1'b1;
		cpu.lds_n = 1'b1;
	endtask

	task automatic expect_end(input logic want_berr, input string what);
		check_value({what, " berr"}, 16'(want_berr), 16'(ended_berr));
	endtask

	task automatic clear_bus_error();
		int waited;
		waited = 0;
		clr_berr = 1'b1;
		while (berr && waited < 8) begin
			@(negedge clk_8);
			waited++;
		end
		check_true(!berr, "berr still high 8 cycles after clr_berr");
		next_edge();
		clr_berr = 1'b0;
	endtask

	task automatic wait_ipl(input logic [2:0] want, input string what);
		int waited;
		waited = 0;
		while (ipl_n !== want && waited < 8) begin
			@(negedge clk_8);
			waited++;
		end
		check_value({what, " ipl_n"}, 16'(want), 16'(ipl_n));
		next_edge();
	endtask

	task automatic sync_pulse(input logic vertical, input logic [2:0] want, input string what);
		if (vertical)
			vsync = 1'b1;
		else
			hsync = 1'b1;
		wait_ipl(want, what);  // edge is taken while the pulse is high
		vsync = 1'b0;
		hsync = 1'b0;
	endtask

	task automatic read_peripheral(input string part, input logic [15:0] offset,
		input logic [5:0] sel, input logic [15:0] data);
		cpu_cycle(word_of({8'hff, offset}), 1'b1, 16'h0000);
		expect_end(1'b0, {part, " read"});
		check_value({part, " io_sel"}, 16'(sel), 16'(seen_sel));
		check_value({part, " data"}, data, seen_rdata);
	endtask

	task automatic test_ram();
		logic [15:0] data;
		int hits;
		test_name = "ram";
		mem_size = mem_4m;
		data = take_bits(16);
		ram_rdata = data;
		cpu_cycle(23'h000800, 1'b1, 16'h0000);
		expect_end(1'b0, "read");
		check_value("read data", data, seen_rdata);
		data = take_bits(16);
		cpu_cycle(23'h000801, 1'b0, data);
		expect_end(1'b0, "write");
		check_true(seen_ram_write, "ram never showed we with the write address and data");
		video_read = 1'b1;
		video_addr = {7'h12, take_bits(16)};  // away from the last cpu address
		repeat (2) begin
			hits = 0;
			repeat (4) begin
				@(negedge clk_8);
				if (ram.addr == video_addr)
					hits++;
			end
			check_true(hits > 0, "video address missing from ram for four cycles");
		end
		next_edge();
		video_read = 1'b0;
	endtask

	// br stalls the cycle well past the watchdog limit without feeding it
	task automatic test_bus_request();
		test_name = "br";
		br = 1'b1;
		cpu.addr = 23'h000800;
		cpu.rw = 1'b1;
		cpu.uds_n = 1'b0;
		cpu.lds_n = 1'b0;
		cpu.as_n = 1'b0;
		repeat (40) begin
			@(negedge clk_8);
			check_true(dtack_n && !berr, "cycle ended while bus request was high");
		end
		next_edge();
		br = 1'b0;
		cpu_cycle(23'h000800, 1'b1, 16'h0000);
		expect_end(1'b0, "read after bus request");
	endtask

	task automatic test_mem_size();
		logic [15:0] data;
		test_name = "mem_size";
		data = take_bits(16);
		mem_size = mem_4m;
		cpu_cycle(word_of(24'h500000), 1'b0, data);
		expect_end(1'b1, "write 0x500000 at 4 MB");
		clear_bus_error();
		mem_size = mem_14m;
		cpu_cycle(word_of(24'h500000), 1'b0, data);
		expect_end(1'b0, "write 0x500000 at 14 MB");
		check_true(seen_ram_write, "write at 0x500000 never reached ram");
		mem_size = mem_4m;
	endtask

	task automatic test_rom();
		logic [23:0] rom_addr [3];
		logic [15:0] data;
		rom_addr = '{24'hfc0000, 24'he00000, 24'hfa0000};  // tos 192k, tos 256k, cartridge
		test_name = "rom";
		data = take_bits(16);
		ram_rdata = data;
		for (int i = 0; i < 3; i++) begin
			cpu_cycle(word_of(rom_addr[i]), 1'b1, 16'h0000);
			expect_end(1'b0, $sformatf("read 0x%h", rom_addr[i]));
			check_value($sformatf("data 0x%h", rom_addr[i]), data, seen_rdata);
		end
		cpu_cycle(word_of(24'hfc0000), 1'b0, data);
		expect_end(1'b1, "write 0xfc0000");  // rom takes no writes
		clear_bus_error();
	endtask

	task automatic test_io();
		test_name = "io";
		io_rdata.vreg = take_bits(16);
		io_rdata.dma = take_bits(16);
		io_rdata.mmu = 8'(take_bits(8));
		io_rdata.mfp = 8'(take_bits(8));
		io_rdata.acia = 8'(take_bits(8));
		io_rdata.psg = 8'(take_bits(8));
		// select bits mmu vreg mfp acia psg dma, msb first
		read_peripheral("mmu", 16'h8000, 6'b100000, {8'h00, io_rdata.mmu});
		read_peripheral("vreg", 16'h8200, 6'b010000, io_rdata.vreg);
		read_peripheral("mfp", 16'hfa00, 6'b001000, {8'h00, io_rdata.mfp});
		read_peripheral("acia", 16'hfc00, 6'b000100, {io_rdata.acia, 8'h00});
		read_peripheral("psg", 16'h8800, 6'b000010, {io_rdata.psg, 8'h00});
		read_peripheral("dma", 16'h8600, 6'b000001, io_rdata.dma);
		cpu_cycle(word_of(24'hff9200), 1'b1, 16'h0000);
		expect_end(1'b1, "unmapped 0xff9200");
		clear_bus_error();
	endtask

	task automatic test_interrupts();
		test_name = "irq";
		sync_pulse(1'b0, 3'b101, "hsync");
		sync_pulse(1'b1, 3'b011, "vsync");  // vbi above hbi
		mfp_irq = 1'b1;
		wait_ipl(3'b001, "mfp");
		mfp_irq = 1'b0;
		wait_ipl(3'b011, "vbi after mfp");
		cpu_cycle(word_of(24'hfffff8), 1'b1, 16'h0000);
		expect_end(1'b0, "level 4 iack");
		check_value("vbi vector", 16'h001c, {8'h00, seen_rdata[7:0]});
		wait_ipl(3'b101, "hbi left after vbi ack");
		cpu_cycle(word_of(24'hfffff4), 1'b1, 16'h0000);
		expect_end(1'b0, "level 2 iack");
		check_value("hbi vector", 16'h001a, {8'h00, seen_rdata[7:0]});
		wait_ipl(3'b111, "after hbi ack");
		cpu_cycle(word_of(24'hfffffc), 1'b1, 16'h0000);
		expect_end(1'b0, "level 6 iack");
		check_value("mfp_iack", 16'h0001, 16'(seen_mfp_iack));
	endtask

	always @(posedge clk_8) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles)
			stop_with_failure($sformatf("%s: run did not finish within %0d cycles",
				test_name, timeout_cycles));
	end

	initial begin
		cpu = '0;
		cpu.as_n = 1'b1;
		cpu.uds_n = 1'b1;
		cpu.lds_n = 1'b1;
		cpu.rw = 1'b1;
		br = 1'b0;
		clr_berr = 1'b0;
		ram_rdata = '0;
		video_addr = '0;
		video_read = 1'b0;
		vsync = 1'b0;
		hsync = 1'b0;
		io_rdata = '0;
		mfp_irq = 1'b0;
		mem_size = mem_4m;
		test_name = "reset";
		@(posedge pll_locked);
		next_edge();
		check_value("ipl_n", 16'h0007, 16'(ipl_n));
		check_value("berr", 16'h0000, 16'(berr));
		test_ram();
		test_bus_request();
		test_mem_size();
		test_rom();
		test_io();
		test_interrupts();
		repeat (4) next_edge();  // bound checks see the last cycles
		if (i_st_glue.i_st_glue_sva.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			stop_with_failure("bus protocol assertion failed during the run");
		end
	end
endmodule

/* hw/cycle_term.sv */
// cycle termination: dtack for answered cycles, watchdog bus error otherwise
`timescale 1ns/1ns

module cycle_term #(
	parameter int WATCHDOG_LIMIT = 7  // counted in cpu slots
) (
	input  logic                  clk_8,
	input  logic                  pll_locked,
	input  st_glue_pkg::cpu_bus_t cpu,
	input  logic                  br,
	input  logic                  clr_berr,
	input  st_glue_pkg::slot_e    slot,
	input  logic                  strobe,
	input  logic                  is_mem,
	input  logic                  io_ack,
	output logic                  dtack_n,
	output logic                  berr
);
	import st_glue_pkg::*;

	localparam int cnt_w = $clog2(WATCHDOG_LIMIT + 1);

	logic             cpu_slot;
	logic [cnt_w-1:0] wd_cnt;  // unanswered cpu slots

	assign cpu_slot = (slot == slot_cpu);

	// br holds the cpu off by withholding dtack
	assign dtack_n = !(cpu_slot && strobe && (is_mem || io_ack) && !br);

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			wd_cnt <= '0;
			berr   <= 1'b0;
		end else if (cpu_slot) begin
			if (berr) begin
				if (clr_berr) begin  // cpu has taken the exception
					berr   <= 1'b0;
					wd_cnt <= '0;
				end
			end else if (cpu.as_n || !dtack_n || br) begin
				wd_cnt <= '0;  // idle, answered or stalled
			end else begin
				wd_cnt <= wd_cnt + 1'b1;
				if (wd_cnt == cnt_w'(WATCHDOG_LIMIT - 1))
					berr <= 1'b1;  // nobody home at this address
			end
		end
	end

endmodule

/* hw/io_decode.sv */
// io decode: peripheral selects, iack levels, autovectors and cpu read mux
`timescale 1ns/1ns

module io_decode (
	input  st_glue_pkg::cpu_bus_t  cpu,
	input  st_glue_pkg::slot_e     slot,
	input  logic                   strobe,
	input  logic                   is_mem,
	input  logic                   is_io,
	input  logic                   is_iack,
	input  st_glue_pkg::io_rdata_t io_rdata,
	input  logic [15:0]            ram_rdata,
	output st_glue_pkg::io_sel_t   io_sel,
	output logic                   mfp_iack,
	output logic                   vbi_ack,
	output logic                   hbi_ack,
	output logic                   io_ack,
	output logic [15:0]            rdata
);
	import st_glue_pkg::*;

	logic        cyc;      // strobed cpu slot
	logic [15:0] io_off;   // byte offset inside io space
	logic [2:0]  lvl;      // A3..A1 during iack
	logic [7:0]  vector;
	logic [7:0]  lane_hi, lane_lo;
	logic [15:0] io_data;

	function automatic logic win_hit(input logic [15:0] off, input logic [15:0] base,
		input logic [15:0] mask);
		return (off & mask) == base;
	endfunction

	assign cyc    = (slot == slot_cpu) && strobe;
	assign io_off = {cpu.addr[14:0], 1'b0};
	assign lvl    = cpu.addr[2:0];

	always_comb begin
		io_sel      = '0;
		io_sel.mmu  = win_hit(io_off, mmu_base, mmu_mask);
		io_sel.vreg = win_hit(io_off, vreg_base, vreg_mask);
		io_sel.mfp  = win_hit(io_off, mfp_base, mfp_mask);
		io_sel.acia = win_hit(io_off, acia_base, acia_mask);
		io_sel.psg  = win_hit(io_off, psg_base, psg_mask);
		io_sel.dma  = win_hit(io_off, dma_base, dma_mask);
		if (!(cyc && is_io))
			io_sel = '0;  // selects only live in the strobed cpu slot
	end

	assign mfp_iack = cyc && is_iack && (lvl == iack_mfp);  // mfp supplies its own vector
	assign vbi_ack  = cyc && is_iack && (lvl == iack_vbi);
	assign hbi_ack  = cyc && is_iack && (lvl == iack_hbi);
	assign io_ack   = (|io_sel) || mfp_iack || vbi_ack || hbi_ack;

	assign vector = ({8{vbi_ack}} & vec_vbi) | ({8{hbi_ack}} & vec_hbi);

	// 8 bit parts sit on the lane of their byte address
	assign lane_hi = ({8{io_sel.acia}} & io_rdata.acia) | ({8{io_sel.psg}} & io_rdata.psg);
	assign lane_lo = ({8{io_sel.mmu}} & io_rdata.mmu) | ({8{io_sel.mfp}} & io_rdata.mfp) |
		vector;

	assign io_data = ({16{io_sel.vreg}} & io_rdata.vreg) |
		({16{io_sel.dma}} & io_rdata.dma) |
		{lane_hi, lane_lo};

	assign rdata = is_mem ? ram_rdata : io_data;

endmodule

/* hw/irq_ctrl.sv */
// interrupt control: vbi/hbi edge capture, pending flags and ipl priority encoder
`timescale 1ns/1ns

module irq_ctrl (
	input  logic       clk_8,
	input  logic       pll_locked,
	input  logic       vsync,
	input  logic       hsync,
	input  logic       mfp_irq,   // level 6, already synchronous
	input  logic       vbi_ack,
	input  logic       hbi_ack,
	output logic [2:0] ipl_n
);
	localparam int vbi_idx = 0;
	localparam int hbi_idx = 1;

	// ipl0 stays high on the st, so only levels 6, 4 and 2 exist
	localparam logic [2:0] ipl_mfp  = 3'b001;
	localparam logic [2:0] ipl_vbi  = 3'b011;
	localparam logic [2:0] ipl_hbi  = 3'b101;
	localparam logic [2:0] ipl_none = 3'b111;

	logic [1:0]      sync_in;
	logic [1:0][2:0] sync_sh;  // [0] meta, [1] synced, [2] previous
	logic [1:0]      rise;
	logic [1:0]      ack;
	logic [1:0]      pending;

	assign sync_in = {hsync, vsync};
	assign ack     = {hbi_ack, vbi_ack};

	always_comb begin
		for (int i = 0; i < 2; i++)
			rise[i] = sync_sh[i][1] && !sync_sh[i][2];
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			sync_sh <= '0;
			pending <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				sync_sh[i] <= {sync_sh[i][1:0], sync_in[i]};
				if (ack[i])
					pending[i] <= 1'b0;  // ack wins over a new edge
				else if (rise[i])
					pending[i] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked)
			ipl_n <= ipl_none;
		else if (mfp_irq)
			ipl_n <= ipl_mfp;
		else if (pending[vbi_idx])
			ipl_n <= ipl_vbi;
		else if (pending[hbi_idx])
			ipl_n <= ipl_hbi;
		else
			ipl_n <= ipl_none;
	end

endmodule

/* hw/mem_map_decode.sv */
// cpu memory map: ram under the configured size, rom, io and iack regions
`timescale 1ns/1ns

module mem_map_decode (
	input  st_glue_pkg::cpu_bus_t  cpu,
	input  st_glue_pkg::mem_size_e mem_size,
	output logic                   is_ram,
	output logic                   is_mem,
	output logic                   is_io,
	output logic                   is_iack
);
	import st_glue_pkg::*;

	logic [7:0] top;  // A23..A16
	logic       ram_0_4, ram_4_8, ram_8_14;
	logic       rom;

	assign top = cpu.addr[22:15];

	assign ram_0_4  = (cpu.addr[22:21] == 2'b00);  // always present
	assign ram_4_8  = (cpu.addr[22:21] == 2'b01);
	assign ram_8_14 = (cpu.addr[22:21] == 2'b10) ||
		(cpu.addr[22:20] == 3'b110);                // up to $e00000

	assign is_ram = ram_0_4 ||
		(((mem_size == mem_8m) || (mem_size == mem_14m)) && ram_4_8) ||
		((mem_size == mem_14m) && ram_8_14);

	// tos 256k, tos 192k, cartridge
	assign rom = (cpu.addr[22:17] == tos256_base) ||
		((top >= tos192_lo) && (top <= tos192_hi)) ||
		((top >= cart_lo) && (top <= cart_hi));

	assign is_mem  = is_ram || (cpu.rw && rom);  // rom only answers reads
	assign is_io   = (top == io_base);
	assign is_iack = (cpu.addr[22:3] == iack_base);

endmodule

/* hw/ram_slot_arbiter.sv */
// st ram slot sequencer: four slot rotation, cpu strobe and shared ram request
`timescale 1ns/1ns

module ram_slot_arbiter (
	input  logic                  clk_8,
	input  logic                  pll_locked,
	input  st_glue_pkg::cpu_bus_t cpu,
	input  logic                  br,
	input  logic                  is_mem,      // cpu may read here
	input  logic                  is_ram,      // cpu may write here
	input  logic [22:0]           video_addr,
	input  logic                  video_read,
	output st_glue_pkg::slot_e    slot,
	output logic                  strobe,
	output st_glue_pkg::ram_req_t ram
);
	import st_glue_pkg::*;

	// video, cpu, io, spare, one clk_8 each
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			slot <= slot_video;
		end else begin
			slot <= slot_e'(slot + 2'd1);  // wraps spare -> video
		end
	end

	// sampled at end of video slot, so high only through the cpu slot
	always_ff @(posedge clk_8 or negedge pll_locked) begin
		if (!pll_locked) begin
			strobe <= 1'b0;
		end else begin
			strobe <= (slot == slot_video) && !cpu.as_n && !br;
		end
	end

	always_comb begin
		ram = '0;  // io and spare slots leave ram idle
		case (slot)
			slot_video: begin
				ram.addr = video_addr;
				ram.oe   = video_read;
				ram.ube  = 1'b1;  // video always fetches whole words
				ram.lbe  = 1'b1;
			end
			slot_cpu: begin
				ram.addr  = cpu.addr;
				ram.oe    = strobe && cpu.rw && is_mem;   // ram and rom reads
				ram.we    = strobe && !cpu.rw && is_ram;  // rom is never written
				ram.ube   = !cpu.uds_n;
				ram.lbe   = !cpu.lds_n;
				ram.wdata = cpu.wdata;
			end
			default: ;
		endcase
	end

endmodule

/* hw/st_glue.sv */
// st glue top: ties slot arbiter, address decode, io, interrupts and cycle end together
`timescale 1ns/1ns

module st_glue #(
	parameter int WATCHDOG_LIMIT = 7  // cpu slots without dtack before berr
) (
	input  logic                   clk_8,
	input  logic                   pll_locked,
	// cpu
	input  st_glue_pkg::cpu_bus_t  cpu,
	input  logic                   br,
	input  logic                   clr_berr,
	output logic                   dtack_n,
	output logic                   berr,
	output logic [2:0]             ipl_n,
	output logic [15:0]            rdata,
	// st ram
	output st_glue_pkg::ram_req_t  ram,
	input  logic [15:0]            ram_rdata,
	// video
	input  logic [22:0]            video_addr,
	input  logic                   video_read,
	input  logic                   vsync,
	input  logic                   hsync,
	// peripherals
	output st_glue_pkg::io_sel_t   io_sel,
	input  st_glue_pkg::io_rdata_t io_rdata,
	input  logic                   mfp_irq,
	output logic                   mfp_iack,
	// config
	input  st_glue_pkg::mem_size_e mem_size
);
	import st_glue_pkg::*;

	slot_e slot;     // current bus slot
	logic  strobe;   // cpu strobe, valid in cpu slot
	logic  is_ram, is_mem, is_io, is_iack;
	logic  vbi_ack, hbi_ack;
	logic  io_ack;   // some io target answers

	ram_slot_arbiter i_ram_slot_arbiter (
		.clk_8, .pll_locked, .cpu, .br, .is_mem, .is_ram,
		.video_addr, .video_read,
		.slot, .strobe, .ram
	);

	mem_map_decode i_mem_map_decode (
		.cpu, .mem_size,
		.is_ram, .is_mem, .is_io, .is_iack
	);

	io_decode i_io_decode (
		.cpu, .slot, .strobe, .is_mem, .is_io, .is_iack,
		.io_rdata, .ram_rdata,
		.io_sel, .mfp_iack, .vbi_ack, .hbi_ack, .io_ack, .rdata
	);

	irq_ctrl i_irq_ctrl (
		.clk_8, .pll_locked, .vsync, .hsync, .mfp_irq,
		.vbi_ack, .hbi_ack,
		.ipl_n
	);

	cycle_term #(
		.WATCHDOG_LIMIT(WATCHDOG_LIMIT)
	) i_cycle_term (
		.clk_8, .pll_locked, .cpu, .br, .clr_berr,
		.slot, .strobe, .is_mem, .io_ack,
		.dtack_n, .berr
	);

endmodule

/* hw/st_glue_pkg.sv */
// st glue package: bus structs, memory size, address regions and autovectors
package st_glue_pkg;

	// cpu side of one bus cycle, addr is a word address (A23..A1)
	typedef struct packed {
		logic [22:0] addr;
		logic        as_n;   // address strobe
		logic        uds_n;  // upper data strobe
		logic        lds_n;  // lower data strobe
		logic        rw;     // high = read
		logic [15:0] wdata;
	} cpu_bus_t;

	// request towards st ram, all controls active high
	typedef struct packed {
		logic [22:0] addr;
		logic        oe;
		logic        we;
		logic        ube;    // upper byte lane
		logic        lbe;    // lower byte lane
		logic [15:0] wdata;
	} ram_req_t;

	typedef struct packed {
		logic mmu;
		logic vreg;
		logic mfp;
		logic acia;
		logic psg;
		logic dma;
	} io_sel_t;

	// peripherals drive zero when not selected
	typedef struct packed {
		logic [15:0] vreg;
		logic [15:0] dma;
		logic [7:0]  mmu;
		logic [7:0]  mfp;
		logic [7:0]  acia;
		logic [7:0]  psg;
	} io_rdata_t;

	typedef enum logic [2:0] {
		mem_512k, mem_1m, mem_2m, mem_4m, mem_8m, mem_14m
	} mem_size_e;

	typedef enum logic [1:0] {
		slot_video, slot_cpu, slot_io, slot_spare
	} slot_e;

	// regions, compared against the top byte address bits
	localparam logic [7:0]  io_base     = 8'hff;     // A23..A16, $ff0000 up
	localparam logic [19:0] iack_base   = 20'hfffff; // A23..A4, $fffff0 up
	localparam logic [5:0]  tos256_base = 6'h38;     // A23..A18, $e00000-$e3ffff
	localparam logic [7:0]  tos192_lo   = 8'hfc;     // $fc0000-$feffff
	localparam logic [7:0]  tos192_hi   = 8'hfe;
	localparam logic [7:0]  cart_lo     = 8'hfa;     // $fa0000-$fbffff
	localparam logic [7:0]  cart_hi     = 8'hfb;

	// peripheral windows inside io space, low 16 byte address bits
	localparam logic [15:0] mmu_base  = 16'h8000;
	localparam logic [15:0] mmu_mask  = 16'hfffe;  // 2 bytes
	localparam logic [15:0] vreg_base = 16'h8200;
	localparam logic [15:0] vreg_mask = 16'hff80;  // 128 bytes
	localparam logic [15:0] dma_base  = 16'h8600;
	localparam logic [15:0] dma_mask  = 16'hfff0;  // 16 bytes
	localparam logic [15:0] psg_base  = 16'h8800;
	localparam logic [15:0] psg_mask  = 16'hff00;
	localparam logic [15:0] mfp_base  = 16'hfa00;
	localparam logic [15:0] mfp_mask  = 16'hffc0;  // 64 bytes
	localparam logic [15:0] acia_base = 16'hfc00;
	localparam logic [15:0] acia_mask = 16'hff00;

	// iack levels on A3..A1
	localparam logic [2:0] iack_mfp = 3'd6;
	localparam logic [2:0] iack_vbi = 3'd4;
	localparam logic [2:0] iack_hbi = 3'd2;

	localparam logic [7:0] vec_vbi = 8'h1c;  // level 4 autovector
	localparam logic [7:0] vec_hbi = 8'h1a;  // level 2 autovector

endpackage

/* sources.f */
hw/st_glue_pkg.sv
hw/ram_slot_arbiter.sv
hw/mem_map_decode.sv
hw/io_decode.sv
hw/irq_ctrl.sv
hw/cycle_term.sv
hw/st_glue.sv
bench/clock_gen.sv
bench/st_glue_sva.sv
bench/st_glue_tb.sv
